/* Makefile */
# Verilator build and run for the union-find decoder testbench

VERILATOR ?= verilator
TOP ?= tb_uf_decoder
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VERILATOR_FLAGS"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Test passed" $(LOG) || { echo "no pass message in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/decoder_array.sv */
module decoder_array (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic                                           load_syndromes,
    input  logic                                           grow_step,
    input  logic                                           merging,
    input  logic [uf_pkg::pu_count-1:0]                    syndromes,
    output logic [uf_pkg::pu_count*uf_pkg::address_width-1:0] roots,
    output logic [uf_pkg::pu_count-1:0]                    touching,
    output logic                                           changed
);

    logic [uf_pkg::pu_count-1:0] in_cluster;
    logic [uf_pkg::pu_count-1:0] unit_changed;
    // neighbor slots: 0 up, 1 down, 2 left, 3 right
    logic [3:0][uf_pkg::address_width-1:0] nbr_roots [uf_pkg::pu_count];
    logic [3:0] nbr_touching [uf_pkg::pu_count];

    assign changed = merging && (|unit_changed);

    for (genvar n = 0; n < uf_pkg::pu_count; n++) begin : pu_g
        processing_unit #(
            .pu_address(uf_pkg::address_width'(n))
        ) i_pu (
            .clk(clk),
            .reset(reset),
            .load_syndromes(load_syndromes),
            .grow_step(grow_step),
            .is_error_syndrome(syndromes[n]),
            .on_boundary(n % uf_pkg::cols == 0 || n % uf_pkg::cols == uf_pkg::cols - 1),
            .neighbor_roots(nbr_roots[n]),
            .neighbor_touching(nbr_touching[n]),
            .root(roots[n*uf_pkg::address_width +: uf_pkg::address_width]),
            .touching(touching[n]),
            .in_cluster(in_cluster[n]),
            .changed(unit_changed[n])
        );

        // each unit owns the links to its right and below
        if (n % uf_pkg::cols != uf_pkg::cols - 1) begin : right_g
            neighbor_link i_link (
                .clk(clk),
                .reset(reset),
                .load_syndromes(load_syndromes),
                .grow_step(grow_step),
                .a_in_cluster(in_cluster[n]),
                .b_in_cluster(in_cluster[n+1]),
                .a_root(roots[n*uf_pkg::address_width +: uf_pkg::address_width]),
                .b_root(roots[(n+1)*uf_pkg::address_width +: uf_pkg::address_width]),
                .a_touching(touching[n]),
                .b_touching(touching[n+1]),
                .root_to_a(nbr_roots[n][3]),
                .root_to_b(nbr_roots[n+1][2]),
                .touching_to_a(nbr_touching[n][3]),
                .touching_to_b(nbr_touching[n+1][2])
            );
        end else begin : right_edge_g
            assign nbr_roots[n][3] = uf_pkg::no_root;
            assign nbr_touching[n][3] = 1'b0;
        end

        if (n + uf_pkg::cols < uf_pkg::pu_count) begin : down_g
            neighbor_link i_link (
                .clk(clk),
                .reset(reset),
                .load_syndromes(load_syndromes),
                .grow_step(grow_step),
                .a_in_cluster(in_cluster[n]),
                .b_in_cluster(in_cluster[n+uf_pkg::cols]),
                .a_root(roots[n*uf_pkg::address_width +: uf_pkg::address_width]),
                .b_root(roots[(n+uf_pkg::cols)*uf_pkg::address_width +: uf_pkg::address_width]),
                .a_touching(touching[n]),
                .b_touching(touching[n+uf_pkg::cols]),
                .root_to_a(nbr_roots[n][1]),
                .root_to_b(nbr_roots[n+uf_pkg::cols][0]),
                .touching_to_a(nbr_touching[n][1]),
                .touching_to_b(nbr_touching[n+uf_pkg::cols][0])
            );
        end else begin : bottom_edge_g
            assign nbr_roots[n][1] = uf_pkg::no_root;
            assign nbr_touching[n][1] = 1'b0;
        end

        if (n % uf_pkg::cols == 0) begin : left_edge_g
            assign nbr_roots[n][2] = uf_pkg::no_root;
            assign nbr_touching[n][2] = 1'b0;
        end

        if (n < uf_pkg::cols) begin : top_edge_g
            assign nbr_roots[n][0] = uf_pkg::no_root;
            assign nbr_touching[n][0] = 1'b0;
        end
    end

endmodule

/* design/neighbor_link.sv */
module neighbor_link (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             load_syndromes,
    input  logic                             grow_step,
    input  logic                             a_in_cluster,
    input  logic                             b_in_cluster,
    input  logic [uf_pkg::address_width-1:0] a_root,
    input  logic [uf_pkg::address_width-1:0] b_root,
    input  logic                             a_touching,
    input  logic                             b_touching,
    output logic [uf_pkg::address_width-1:0] root_to_a,
    output logic [uf_pkg::address_width-1:0] root_to_b,
    output logic                             touching_to_a,
    output logic                             touching_to_b
);

    logic [uf_pkg::growth_width-1:0] growth;
    logic [uf_pkg::growth_width:0] growth_sum;
    logic fully_grown;

    // both ends of the edge grow toward each other
    assign growth_sum = growth + a_in_cluster + b_in_cluster;
    assign fully_grown = growth == uf_pkg::neighbor_cost;

    always_ff @(posedge clk) begin
        if (reset || load_syndromes) begin
            growth <= '0;
            root_to_a <= uf_pkg::no_root;
            root_to_b <= uf_pkg::no_root;
            touching_to_a <= 1'b0;
            touching_to_b <= 1'b0;
        end else begin
            if (grow_step) begin
                growth <= (growth_sum >= uf_pkg::neighbor_cost)
                    ? uf_pkg::growth_width'(uf_pkg::neighbor_cost)
                    : growth_sum[uf_pkg::growth_width-1:0];
            end
            root_to_a <= fully_grown ? b_root : uf_pkg::no_root;
            root_to_b <= fully_grown ? a_root : uf_pkg::no_root;
            touching_to_a <= fully_grown && b_touching;
            touching_to_b <= fully_grown && a_touching;
        end
    end

endmodule

/* design/processing_unit.sv */
module processing_unit #(
    parameter logic [uf_pkg::address_width-1:0] pu_address = '0
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 load_syndromes,
    input  logic                                 grow_step,
    input  logic                                 is_error_syndrome,
    input  logic                                 on_boundary,
    input  logic [3:0][uf_pkg::address_width-1:0] neighbor_roots,
    input  logic [3:0]                           neighbor_touching,
    output logic [uf_pkg::address_width-1:0]     root,
    output logic                                 touching,
    output logic                                 in_cluster,
    output logic                                 changed
);

    logic [uf_pkg::address_width-1:0] merged_root;
    logic next_touching;
    logic [uf_pkg::growth_width-1:0] boundary_growth;
    logic [uf_pkg::growth_width-1:0] growth_next;

    assign in_cluster = root != uf_pkg::no_root;

    // no_root is the largest code, so the minimum keeps any real root
    always_comb begin
        merged_root = root;
        for (int n = 0; n < 4; n++) begin
            if (neighbor_roots[n] < merged_root) begin
                merged_root = neighbor_roots[n];
            end
        end
    end

    always_comb begin
        growth_next = boundary_growth;
        if (grow_step && in_cluster && on_boundary && boundary_growth < uf_pkg::boundary_cost) begin
            growth_next = boundary_growth + 1'b1;
        end
    end

    assign next_touching = touching || (|neighbor_touching)
        || (growth_next == uf_pkg::boundary_cost);
    assign changed = (merged_root != root) || (next_touching != touching);

    always_ff @(posedge clk) begin
        if (reset) begin
            root <= uf_pkg::no_root;
            touching <= 1'b0;
            boundary_growth <= '0;
        end else if (load_syndromes) begin
            root <= is_error_syndrome ? pu_address : uf_pkg::no_root;
            touching <= 1'b0;
            boundary_growth <= '0;
        end else begin
            root <= merged_root;
            touching <= next_touching;
            boundary_growth <= growth_next;
        end
    end

endmodule

/* design/stage_controller.sv */
module stage_controller (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    input  logic [uf_pkg::round_width-1:0] rounds,
    input  logic                         changed,
    output logic                         load_syndromes,
    output logic                         grow_step,
    output logic                         merging,
    output logic                         busy,
    output logic                         done
);

    uf_pkg::stage_t state;
    logic [uf_pkg::round_width-1:0] rounds_left;
    // one quiet merge cycle already seen
    logic quiet;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= uf_pkg::idle;
            rounds_left <= '0;
            quiet <= 1'b0;
        end else begin
            case (state)
                uf_pkg::idle, uf_pkg::done: begin
                    if (start) begin
                        state <= uf_pkg::load;
                        rounds_left <= rounds;
                    end
                end
                uf_pkg::load: begin
                    state <= (rounds_left == '0) ? uf_pkg::done : uf_pkg::grow;
                end
                uf_pkg::grow: begin
                    rounds_left <= rounds_left - 1'b1;
                    quiet <= 1'b0;
                    state <= uf_pkg::merge;
                end
                uf_pkg::merge: begin
                    // links add a cycle, so a single quiet cycle is not yet a fixpoint
                    if (changed) begin
                        quiet <= 1'b0;
                    end else if (!quiet) begin
                        quiet <= 1'b1;
                    end else if (rounds_left == '0) begin
                        state <= uf_pkg::done;
                    end else begin
                        state <= uf_pkg::grow;
                    end
                end
                default: begin
                    state <= uf_pkg::idle;
                end
            endcase
        end
    end

    assign load_syndromes = state == uf_pkg::load;
    assign grow_step = state == uf_pkg::grow;
    assign merging = state == uf_pkg::merge;
    assign busy = load_syndromes || grow_step || merging;
    assign done = state == uf_pkg::done;

endmodule

/* design/uf_decoder_top.sv */
module uf_decoder_top (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             wb_cyc,
    input  logic                             wb_stb,
    input  logic                             wb_we,
    input  logic [uf_pkg::wb_addr_width-1:0] wb_adr,
    input  logic [uf_pkg::wb_data_width-1:0] wb_dat_w,
    output logic [uf_pkg::wb_data_width-1:0] wb_dat_r,
    output logic                             wb_ack
);

    logic start;
    logic [uf_pkg::round_width-1:0] rounds;
    logic busy;
    logic done;
    logic load_syndromes;
    logic grow_step;
    logic merging;
    logic changed;
    logic [uf_pkg::pu_count-1:0] syndromes;
    logic [uf_pkg::pu_count*uf_pkg::address_width-1:0] roots;
    logic [uf_pkg::pu_count-1:0] touching;

    wb_decoder_regs i_regs (
        .clk(clk),
        .reset(reset),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack),
        .busy(busy),
        .done(done),
        .roots(roots),
        .touching(touching),
        .start(start),
        .rounds(rounds),
        .syndromes(syndromes)
    );

    stage_controller i_controller (
        .clk(clk),
        .reset(reset),
        .start(start),
        .rounds(rounds),
        .changed(changed),
        .load_syndromes(load_syndromes),
        .grow_step(grow_step),
        .merging(merging),
        .busy(busy),
        .done(done)
    );

    decoder_array i_array (
        .clk(clk),
        .reset(reset),
        .load_syndromes(load_syndromes),
        .grow_step(grow_step),
        .merging(merging),
        .syndromes(syndromes),
        .roots(roots),
        .touching(touching),
        .changed(changed)
    );

endmodule

/* design/uf_pkg.sv */
package uf_pkg;

    // planar surface code lattice, one layer of syndromes
    localparam int code_distance = 5;
    localparam int rows = code_distance;
    localparam int cols = code_distance - 1;
    localparam int pu_count = rows * cols;

    // the all-ones address is never a unit and marks a unit outside every cluster
    localparam int address_width = $clog2(pu_count + 1);
    localparam logic [address_width-1:0] no_root = '1;

    // growth steps until an edge or the boundary is fully grown
    localparam int neighbor_cost = 2;
    localparam int boundary_cost = 2;
    localparam int max_cost = (neighbor_cost > boundary_cost) ? neighbor_cost : boundary_cost;
    localparam int growth_width = $clog2(max_cost + 1);

    localparam int round_width = 4;

    // wishbone word addresses
    localparam int wb_addr_width = 6;
    localparam int wb_data_width = 32;
    localparam logic [wb_addr_width-1:0] reg_addr_control = 6'h00;
    localparam logic [wb_addr_width-1:0] reg_addr_status = 6'h01;
    localparam logic [wb_addr_width-1:0] reg_addr_syndrome = 6'h02;
    localparam logic [wb_addr_width-1:0] reg_addr_touching = 6'h03;
    localparam logic [wb_addr_width-1:0] reg_addr_root_base = 6'h10;

    typedef enum logic [2:0] {
        idle,
        load,
        grow,
        merge,
        done
    } stage_t;

endpackage

/* design/wb_decoder_regs.sv */
module wb_decoder_regs (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic                                           wb_cyc,
    input  logic                                           wb_stb,
    input  logic                                           wb_we,
    input  logic [uf_pkg::wb_addr_width-1:0]               wb_adr,
    input  logic [uf_pkg::wb_data_width-1:0]               wb_dat_w,
    output logic [uf_pkg::wb_data_width-1:0]               wb_dat_r,
    output logic                                           wb_ack,
    input  logic                                           busy,
    input  logic                                           done,
    input  logic [uf_pkg::pu_count*uf_pkg::address_width-1:0] roots,
    input  logic [uf_pkg::pu_count-1:0]                    touching,
    output logic                                           start,
    output logic [uf_pkg::round_width-1:0]                 rounds,
    output logic [uf_pkg::pu_count-1:0]                    syndromes
);

    logic request;
    // current strobe already answered, wait for it to drop
    logic served;
    logic [uf_pkg::wb_addr_width-1:0] root_index;
    logic [uf_pkg::wb_data_width-1:0] read_data;

    assign request = wb_cyc && wb_stb;
    assign root_index = wb_adr - uf_pkg::reg_addr_root_base;

    always_comb begin
        read_data = '0;
        case (wb_adr)
            uf_pkg::reg_addr_control: read_data[7:4] = rounds;
            uf_pkg::reg_addr_status: read_data[1:0] = {done, busy};
            uf_pkg::reg_addr_syndrome: read_data[uf_pkg::pu_count-1:0] = syndromes;
            uf_pkg::reg_addr_touching: read_data[uf_pkg::pu_count-1:0] = touching;
            default: begin
                // addresses below the root window wrap to a large index
                if (root_index < uf_pkg::pu_count) begin
                    read_data[uf_pkg::address_width-1:0] =
                        roots[root_index*uf_pkg::address_width +: uf_pkg::address_width];
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
            served <= 1'b0;
            start <= 1'b0;
            rounds <= '0;
            syndromes <= '0;
        end else begin
            wb_ack <= 1'b0;
            start <= 1'b0;
            if (!request) begin
                served <= 1'b0;
            end else if (!served) begin
                wb_ack <= 1'b1;
                served <= 1'b1;
                if (wb_we && wb_adr == uf_pkg::reg_addr_control && !busy) begin
                    start <= wb_dat_w[0];
                    rounds <= wb_dat_w[7:4];
                end
                if (wb_we && wb_adr == uf_pkg::reg_addr_syndrome) begin
                    syndromes <= wb_dat_w[uf_pkg::pu_count-1:0];
                end
            end
        end
    end

    // read data is captured together with the ack
    always_ff @(posedge clk) begin
        if (request && !served) begin
            wb_dat_r <= read_data;
        end
    end

endmodule

/* sources.f */
design/uf_pkg.sv
design/stage_controller.sv
design/processing_unit.sv
design/neighbor_link.sv
design/decoder_array.sv
design/wb_decoder_regs.sv
design/uf_decoder_top.sv
testbench/tb_uf_decoder.sv

/* testbench/tb_uf_decoder.sv */
module tb_uf_decoder;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int pu_count = uf_pkg::pu_count;
    localparam int cols = uf_pkg::cols;
    localparam int ack_timeout = 16;
    localparam int poll_limit = 400;

    logic clk;
    logic reset;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [uf_pkg::wb_addr_width-1:0] wb_adr;
    logic [uf_pkg::wb_data_width-1:0] wb_dat_w;
    logic [uf_pkg::wb_data_width-1:0] wb_dat_r;
    logic wb_ack;

    int errors;
    int checks;
    bit aborted;
    logic [31:0] lfsr_state;

    // reference model state
    int model_root [pu_count];
    bit model_touch [pu_count];
    int boundary_count [pu_count];
    // h_growth[n] is the edge n to n+1, v_growth[n] the edge n to n+cols
    int h_growth [pu_count];
    int v_growth [pu_count];

    // last values read back from the DUT
    logic [31:0] read_root [pu_count];
    logic [31:0] read_touching;

    uf_decoder_top i_dut (
        .clk(clk),
        .reset(reset),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (!aborted) begin
            checks++;
            assert (got == expected) else begin
                errors++;
                $display("mismatch at %0t ns: %s is %0h, expected %0h",
                         $time, name, got, expected);
            end
        end
    endtask

    task automatic wb_access(input bit write, input logic [uf_pkg::wb_addr_width-1:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        rdata = '0;
        if (!aborted) begin
            @(posedge clk);
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
            wb_we <= write;
            wb_adr <= adr;
            wb_dat_w <= wdata;
            waited = 0;
            @(negedge clk);
            while (!wb_ack && waited < ack_timeout) begin
                waited++;
                @(negedge clk);
            end
            if (wb_ack) begin
                rdata = wb_dat_r;
                check_value("wb_ack delay in cycles", waited, 1);
            end else begin
                errors++;
                aborted = 1'b1;
                $display("no wb_ack from the DUT within %0d cycles at address %0h",
                         ack_timeout, adr);
            end
            @(posedge clk);
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we <= 1'b0;
            @(negedge clk);
            check_value("wb_ack after strobe release", wb_ack, 0);
        end
    endtask

    task automatic wb_write(input logic [uf_pkg::wb_addr_width-1:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [uf_pkg::wb_addr_width-1:0] adr, output logic [31:0] data);
        wb_access(1'b0, adr, 32'h0, data);
    endtask

    task automatic wait_done();
        int polls;
        logic [31:0] status;
        polls = 0;
        wb_read(uf_pkg::reg_addr_status, status);
        while (!status[1] && polls < poll_limit && !aborted) begin
            polls++;
            wb_read(uf_pkg::reg_addr_status, status);
        end
        if (!aborted && !status[1]) begin
            errors++;
            aborted = 1'b1;
            $display("decoder did not report done within %0d status polls", poll_limit);
        end
        // done set, busy clear
        check_value("status", status, 32'h2);
    endtask

    function automatic bit is_boundary(input int n);
        return (n % cols == 0) || (n % cols == cols - 1);
    endfunction

    task automatic model_load(input logic [31:0] syn);
        for (int n = 0; n < pu_count; n++) begin
            model_root[n] = syn[n] ? n : int'(uf_pkg::no_root);
            model_touch[n] = 1'b0;
            boundary_count[n] = 0;
            h_growth[n] = 0;
            v_growth[n] = 0;
        end
    endtask

    task automatic model_round(input logic [31:0] syn);
        bit member [pu_count];
        bit visited [pu_count];
        int pending [$];
        int component [$];
        int node;
        int min_defect;
        bit any_touch;
        for (int n = 0; n < pu_count; n++) begin
            member[n] = model_root[n] != int'(uf_pkg::no_root);
            visited[n] = 1'b0;
        end
        // both endpoints grow into the edge
        for (int n = 0; n < pu_count; n++) begin
            if (n % cols != cols - 1) begin
                h_growth[n] = h_growth[n] + member[n] + member[n+1];
                if (h_growth[n] > uf_pkg::neighbor_cost) begin
                    h_growth[n] = uf_pkg::neighbor_cost;
                end
            end
            if (n + cols < pu_count) begin
                v_growth[n] = v_growth[n] + member[n] + member[n+cols];
                if (v_growth[n] > uf_pkg::neighbor_cost) begin
                    v_growth[n] = uf_pkg::neighbor_cost;
                end
            end
        end
        for (int n = 0; n < pu_count; n++) begin
            if (member[n] && is_boundary(n)) begin
                if (boundary_count[n] < uf_pkg::boundary_cost) begin
                    boundary_count[n]++;
                end
                if (boundary_count[n] == uf_pkg::boundary_cost) begin
                    model_touch[n] = 1'b1;
                end
            end
        end
        // breadth-first search over fully grown edges
        for (int start = 0; start < pu_count; start++) begin
            if (!visited[start]) begin
                visited[start] = 1'b1;
                pending.push_back(start);
                component.delete();
                while (pending.size() > 0) begin
                    node = pending.pop_front();
                    component.push_back(node);
                    if (node >= cols && v_growth[node-cols] == uf_pkg::neighbor_cost
                        && !visited[node-cols]) begin
                        visited[node-cols] = 1'b1;
                        pending.push_back(node - cols);
                    end
                    if (node + cols < pu_count && v_growth[node] == uf_pkg::neighbor_cost
                        && !visited[node+cols]) begin
                        visited[node+cols] = 1'b1;
                        pending.push_back(node + cols);
                    end
                    if (node % cols != 0 && h_growth[node-1] == uf_pkg::neighbor_cost
                        && !visited[node-1]) begin
                        visited[node-1] = 1'b1;
                        pending.push_back(node - 1);
                    end
                    if (node % cols != cols - 1 && h_growth[node] == uf_pkg::neighbor_cost
                        && !visited[node+1]) begin
                        visited[node+1] = 1'b1;
                        pending.push_back(node + 1);
                    end
                end
                min_defect = int'(uf_pkg::no_root);
                any_touch = 1'b0;
                foreach (component[i]) begin
                    if (syn[component[i]] && component[i] < min_defect) begin
                        min_defect = component[i];
                    end
                    any_touch = any_touch | model_touch[component[i]];
                end
                if (min_defect != int'(uf_pkg::no_root)) begin
                    foreach (component[i]) begin
                        model_root[component[i]] = min_defect;
                        model_touch[component[i]] = any_touch;
                    end
                end
            end
        end
    endtask

    task automatic compare_results();
        logic [31:0] data;
        logic [31:0] expected_touching;
        logic [uf_pkg::wb_addr_width-1:0] adr;
        expected_touching = '0;
        for (int n = 0; n < pu_count; n++) begin
            adr = uf_pkg::reg_addr_root_base + uf_pkg::wb_addr_width'(n);
            wb_read(adr, data);
            read_root[n] = data;
            check_value($sformatf("root[%0d]", n), data, model_root[n]);
            expected_touching[n] = model_touch[n];
        end
        wb_read(uf_pkg::reg_addr_touching, data);
        read_touching = data;
        check_value("touching", data, expected_touching);
    endtask

    task automatic decode_and_check(input logic [31:0] syn, input int rounds);
        model_load(syn);
        for (int r = 0; r < rounds; r++) begin
            model_round(syn);
        end
        wb_write(uf_pkg::reg_addr_syndrome, syn);
        wb_write(uf_pkg::reg_addr_control, 32'h1 | (rounds << 4));
        wait_done();
        compare_results();
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic test_reset_values();
        int errors_before;
        logic [31:0] status;
        errors_before = errors;
        wb_read(uf_pkg::reg_addr_status, status);
        check_value("status", status, 32'h0);
        model_load(32'h0);
        compare_results();
        report_test("reset_values", errors_before);
    endtask

    task automatic test_single_defect();
        int errors_before;
        errors_before = errors;
        // row 2, column 1
        decode_and_check(32'h1 << 9, 1);
        check_value("root of the defect", read_root[9], 9);
        check_value("touching", read_touching, 0);
        report_test("single_defect", errors_before);
    endtask

    task automatic test_adjacent_merge();
        int errors_before;
        errors_before = errors;
        decode_and_check((32'h1 << 9) | (32'h1 << 10), 1);
        check_value("root[9]", read_root[9], 9);
        check_value("root[10]", read_root[10], 9);
        report_test("adjacent_merge", errors_before);
    endtask

    task automatic test_boundary_growth();
        int errors_before;
        errors_before = errors;
        // row 2, column 0
        decode_and_check(32'h1 << 8, 1);
        check_value("touching[8] after one round", read_touching[8], 0);
        decode_and_check(32'h1 << 8, 2);
        check_value("touching[8] after two rounds", read_touching[8], 1);
        report_test("boundary_growth", errors_before);
    endtask

    task automatic test_random_runs();
        int errors_before;
        logic [31:0] syn;
        logic [31:0] rounds;
        errors_before = errors;
        for (int run = 0; run < 20; run++) begin
            take_bits(pu_count, syn);
            take_bits(2, rounds);
            decode_and_check(syn, rounds);
        end
        report_test("random_runs", errors_before);
    endtask

    task automatic test_start_while_busy();
        int errors_before;
        logic [31:0] syn;
        logic [31:0] status;
        errors_before = errors;
        syn = (32'h1 << 5) | (32'h1 << 14);
        model_load(syn);
        for (int r = 0; r < 3; r++) begin
            model_round(syn);
        end
        wb_write(uf_pkg::reg_addr_syndrome, syn);
        wb_write(uf_pkg::reg_addr_control, 32'h31);
        wb_read(uf_pkg::reg_addr_status, status);
        check_value("status busy bit", status[0], 1);
        // would end the run right after load if it were taken
        wb_write(uf_pkg::reg_addr_control, 32'h01);
        wait_done();
        compare_results();
        report_test("start_while_busy", errors_before);
    endtask

    initial begin
        errors = 0;
        checks = 0;
        aborted = 1'b0;
        lfsr_state = 32'h1666_066e;
        reset = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        test_reset_values();
        test_single_defect();
        test_adjacent_merge();
        test_boundary_growth();
        test_random_runs();
        test_start_while_busy();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && !aborted) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
